/* all.f */
rtl/core6502Pkg.sv
rtl/preDecode.sv
rtl/dispatch.sv
rtl/regFile.sv
rtl/alu.sv
rtl/flags.sv
rtl/core6502.sv
sim/tbMemory.sv
sim/tbCore6502.sv

/* rtl/alu.sv */
// ALU: binary add with carry, logic ops, shift right and pass
`timescale 1ns/1ps
`default_nettype none

module alu import core6502Pkg::*; (
	input aluOpE aluOp,
	input byteT aluA,						// Register side
	input byteT aluB,						// Operand side
	input logic carryIn,
	output byteT aluY,
	output logic carryOut,
	output logic overflowOut
);

	logic [8:0] sum;						// Add with carry out on top

	assign sum = {1'b0, aluA} + {1'b0, aluB} + {8'h00, carryIn};

	always_comb begin
		aluY = aluA | aluB;
		carryOut = carryIn;					// Logic ops keep carry
		overflowOut = 1'b0;
		case (aluOp)
			opPass: aluY = aluA | aluB;		// Only one side is live
			opAdc: begin
				aluY = sum[7:0];
				carryOut = sum[8];
				// Same input signs, different result sign
				overflowOut = ~(aluA[7] ^ aluB[7]) & (aluA[7] ^ sum[7]);
			end
			opAnd: aluY = aluA & aluB;
			opOra: aluY = aluA | aluB;
			opEor: aluY = aluA ^ aluB;
			opLsr: begin
				aluY = {1'b0, aluA[7:1]};
				carryOut = aluA[0];			// Bit 0 falls into C
			end
			default: aluY = aluA;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/core6502.sv */
// 6502 subset core top: predecoder, sequencer, registers, ALU and flags on one bus
`timescale 1ns/1ps
`default_nettype none

module core6502 import core6502Pkg::*; #(
	parameter addrT resetPc = 16'h0200		// Start address after reset
) (
	input logic phi0,						// Single clock, rising edge
	input logic rstN,
	output addrT addr,
	output logic rnw,						// 1 read, 0 write
	output logic sync,						// Opcode fetch cycle
	output byteT dOut,
	input byteT dIn,
	input logic rdy							// Read cycle ready
);

	// Decode
	opcodeU opcode;
	logic [1:0] instLen;
	logic isStore;
	logic isJump;
	logic [1:0] dstSel;
	logic [1:0] srcSel;
	aluOpE aluOp;
	logic updNz;
	logic updCv;
	logic clcOp;
	logic secOp;

	// Datapath
	byteT operand;
	byteT aluA;
	byteT aluY;
	byteT accOut;
	logic carryIn;
	logic carryOut;
	logic overflowOut;
	logic execEn;

	preDecode pd(
		.opcode(opcode), .instLen(instLen), .isStore(isStore), .isJump(isJump),
		.dstSel(dstSel), .srcSel(srcSel), .aluOp(aluOp),
		.updNz(updNz), .updCv(updCv), .clcOp(clcOp), .secOp(secOp) );

	dispatch #(.resetPc(resetPc)) disp(
		.phi0(phi0), .rstN(rstN), .rdy(rdy), .dIn(dIn),
		.instLen(instLen), .isStore(isStore), .isJump(isJump), .accOut(accOut),
		.opcode(opcode), .operand(operand), .addr(addr), .rnw(rnw),
		.sync(sync), .dOut(dOut), .execEn(execEn) );

	regFile regs(
		.phi0(phi0), .rstN(rstN), .execEn(execEn), .dstSel(dstSel),
		.srcSel(srcSel), .aluY(aluY), .aluA(aluA), .accOut(accOut) );

	alu alu(
		.aluOp(aluOp), .aluA(aluA), .aluB(operand), .carryIn(carryIn),
		.aluY(aluY), .carryOut(carryOut), .overflowOut(overflowOut) );

	flags flags(
		.phi0(phi0), .rstN(rstN), .execEn(execEn), .updNz(updNz),
		.updCv(updCv), .clcOp(clcOp), .secOp(secOp), .aluY(aluY),
		.carryOut(carryOut), .overflowOut(overflowOut), .carryIn(carryIn) );

endmodule

`default_nettype wire

/* rtl/core6502Pkg.sv */
// Core 6502 shared types: bus widths, opcode views, ALU and cycle-state encodings
`default_nettype none

package core6502Pkg;

	typedef logic [15:0] addrT;				// External address bus
	typedef logic [7:0] byteT;				// Data byte

	// Opcode split into its aaa/bbb/cc decode fields
	typedef struct packed {
		logic [2:0] aaa;					// Operation within group
		logic [2:0] bbb;					// Addressing mode
		logic [1:0] cc;						// Instruction group
	} opFieldsT;

	typedef union packed {
		byteT raw;							// Whole byte, length and class lookup
		opFieldsT f;						// Field view, ALU and register select
	} opcodeU;

	typedef enum logic [2:0] {
		opPass,								// Merge of the one live input
		opAdc,								// Binary add with carry
		opAnd,
		opOra,
		opEor,
		opLsr								// Shift right, bit 0 to carry
	} aluOpE;

	typedef enum logic [2:0] {
		tFetch,								// Opcode fetch, SYNC high
		tOp1,								// Operand or dummy read
		tOp2,								// High address byte for STA
		tExec,								// High byte read and PC load for JMP
		tWrite								// Store cycle, RnW low
	} tStateE;

	// Register select codes
	localparam logic [1:0] selNone = 2'd0;
	localparam logic [1:0] selA = 2'd1;
	localparam logic [1:0] selX = 2'd2;
	localparam logic [1:0] selY = 2'd3;

	// Bit positions in the 4-bit P word
	localparam int flagN = 3;
	localparam int flagV = 2;
	localparam int flagZ = 1;
	localparam int flagC = 0;

endpackage

`default_nettype wire

/* rtl/dispatch.sv */
// Cycle sequencer: T-state, program counter, address bus, RnW/SYNC and RDY stall
`timescale 1ns/1ps
`default_nettype none

module dispatch import core6502Pkg::*; #(
	parameter addrT resetPc = 16'h0200		// First fetch address
) (
	input logic phi0,
	input logic rstN,
	input logic rdy,						// Low stalls read cycles
	input byteT dIn,
	input logic [1:0] instLen,
	input logic isStore,
	input logic isJump,
	input byteT accOut,						// Accumulator for STA
	output opcodeU opcode,
	output byteT operand,					// ALU input B
	output addrT addr,
	output logic rnw,
	output logic sync,
	output byteT dOut,
	output logic execEn						// Last cycle of instruction
);

	tStateE state, nextState;
	addrT pc;
	opcodeU opReg;
	byteT opLo;								// Immediate or low address byte
	byteT opHi;								// High address byte
	logic adv;								// Cycle completes this edge

	assign adv = rdy | ~rnw;				// Writes ignore RDY
	assign rnw = (state != tWrite);
	assign sync = (state == tFetch);
	assign addr = (state == tWrite) ? {opHi, opLo} : pc;
	assign dOut = (state == tWrite) ? accOut : 8'h00;
	assign opcode = opReg;

	// Operand straight from the bus on the execute edge
	always_comb begin
		if (instLen == 2'd1)
			operand = 8'h00;				// Implied, keep B quiet
		else if (state == tOp1)
			operand = dIn;
		else
			operand = opLo;
	end

	always_comb begin
		case (state)
			tOp1: execEn = rdy && (instLen != 2'd3);
			tExec: execEn = rdy;
			tWrite: execEn = 1'b1;
			default: execEn = 1'b0;
		endcase
	end

	always_comb begin
		case (state)
			tFetch: nextState = tOp1;
			tOp1: begin
				if (isJump)
					nextState = tExec;
				else if (isStore)
					nextState = tOp2;
				else
					nextState = tFetch;	// Two-cycle done
			end
			tOp2: nextState = tWrite;
			default: nextState = tFetch;	// tExec, tWrite
		endcase
	end

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			state <= tFetch;
			pc <= resetPc;
			opReg.raw <= 8'hEA;				// NOP
		end else if (adv) begin
			state <= nextState;
			case (state)
				tFetch: begin
					opReg.raw <= dIn;
					pc <= pc + 16'd1;
				end
				tOp1: if (instLen != 2'd1) pc <= pc + 16'd1;	// Implied rereads
				tOp2: pc <= pc + 16'd1;
				tExec: pc <= {dIn, opLo};	// JMP target
				default: ;
			endcase
		end
	end

	// Operand latches
	always_ff @(posedge phi0) begin
		if (adv && state == tOp1)
			opLo <= dIn;
		if (adv && state == tOp2)
			opHi <= dIn;
	end

endmodule

`default_nettype wire

/* rtl/flags.sv */
// Status register: N, V, Z and C updates from the ALU and CLC/SEC
`timescale 1ns/1ps
`default_nettype none

module flags import core6502Pkg::*; (
	input logic phi0,
	input logic rstN,
	input logic execEn,
	input logic updNz,
	input logic updCv,
	input logic clcOp,
	input logic secOp,
	input byteT aluY,
	input logic carryOut,
	input logic overflowOut,
	output logic carryIn					// C back to the ALU
);

	logic [3:0] p;							// N V Z C

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			p <= 4'h0;
		end else if (execEn) begin
			if (updNz) begin
				p[flagN] <= aluY[7];
				p[flagZ] <= (aluY == 8'h00);
			end
			if (updCv) begin
				p[flagC] <= carryOut;
				p[flagV] <= overflowOut;
			end
			if (clcOp)
				p[flagC] <= 1'b0;
			if (secOp)
				p[flagC] <= 1'b1;
		end
	end

	assign carryIn = p[flagC];

endmodule

`default_nettype wire

/* rtl/preDecode.sv */
// Predecoder: instruction length, bus class and register/ALU/flag selects from the opcode
`timescale 1ns/1ps
`default_nettype none

module preDecode import core6502Pkg::*; (
	input opcodeU opcode,					// Latched opcode
	output logic [1:0] instLen,				// Bytes in instruction, 1..3
	output logic isStore,					// STA abs
	output logic isJump,					// JMP abs
	output logic [1:0] dstSel,				// Register taking the result
	output logic [1:0] srcSel,				// Register feeding ALU input A
	output aluOpE aluOp,
	output logic updNz,						// N/Z follow result
	output logic updCv,						// C/V follow ALU
	output logic clcOp,
	output logic secOp
);

	always_comb begin
		// Default is a one-byte NOP
		instLen = 2'd1;
		isStore = 1'b0;
		isJump = 1'b0;
		dstSel = selNone;
		srcSel = selNone;
		aluOp = opPass;
		updNz = 1'b0;
		updCv = 1'b0;
		clcOp = 1'b0;
		secOp = 1'b0;
		case (opcode.raw)
			8'hA2: begin							// LDX #
				instLen = 2'd2;
				dstSel = selX;
				updNz = 1'b1;
			end
			8'hA0: begin							// LDY #
				instLen = 2'd2;
				dstSel = selY;
				updNz = 1'b1;
			end
			8'h4A: begin							// LSR A
				dstSel = selA;
				srcSel = selA;
				aluOp = opLsr;
				updNz = 1'b1;
				updCv = 1'b1;
			end
			8'hAA: begin							// TAX
				dstSel = selX;
				srcSel = selA;
				updNz = 1'b1;
			end
			8'h8A: begin							// TXA
				dstSel = selA;
				srcSel = selX;
				updNz = 1'b1;
			end
			8'h18: clcOp = 1'b1;					// CLC
			8'h38: secOp = 1'b1;					// SEC
			8'h8D: begin							// STA abs
				instLen = 2'd3;
				isStore = 1'b1;
			end
			8'h4C: begin							// JMP abs
				instLen = 2'd3;
				isJump = 1'b1;
			end
			default: begin
				// Group one immediate forms, op picked by aaa
				if (opcode.f.cc == 2'b01 && opcode.f.bbb == 3'b010) begin
					instLen = 2'd2;
					dstSel = selA;
					srcSel = selA;
					updNz = 1'b1;
					case (opcode.f.aaa)
						3'd0: aluOp = opOra;
						3'd1: aluOp = opAnd;
						3'd2: aluOp = opEor;
						3'd3: begin
							aluOp = opAdc;
							updCv = 1'b1;
						end
						3'd5: srcSel = selNone;		// LDA #, operand only
						default: begin				// STA #, CMP, SBC unsupported
							instLen = 2'd1;
							dstSel = selNone;
							srcSel = selNone;
							updNz = 1'b0;
						end
					endcase
				end
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Register block: A, X and Y with ALU source select and result load
`timescale 1ns/1ps
`default_nettype none

module regFile import core6502Pkg::*; (
	input logic phi0,
	input logic rstN,
	input logic execEn,						// Result write strobe
	input logic [1:0] dstSel,
	input logic [1:0] srcSel,
	input byteT aluY,
	output byteT aluA,						// Selected source register
	output byteT accOut
);

	byteT acc;
	byteT xReg;
	byteT yReg;

	always_comb begin
		case (srcSel)
			selA: aluA = acc;
			selX: aluA = xReg;
			selY: aluA = yReg;
			default: aluA = 8'h00;			// Loads pass operand alone
		endcase
	end

	always_ff @(posedge phi0 or negedge rstN) begin
		if (!rstN) begin
			acc <= 8'h00;
			xReg <= 8'h00;
			yReg <= 8'h00;
		end else if (execEn) begin
			case (dstSel)
				selA: acc <= aluY;
				selX: xReg <= aluY;
				selY: yReg <= aluY;
				default: ;					// No register written
			endcase
		end
	end

	assign accOut = acc;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the core and its testbench with Verilator and run it; exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tbCore6502 -f all.f -o simCore6502 &&
./obj_dir/simCore6502 ||
{ echo "Build or simulation failed"; exit 1; }

/* sim/tbCore6502.sv */
// Testbench for the 6502 subset core: program table, reference model, bus checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tbCore6502 import core6502Pkg::*; ();

	localparam addrT startPc = 16'h0340;	// Away from the core default start address
	localparam int numRows = 31;
	// Instruction script, one row each
	localparam byteT script [0:numRows-1] = '{
		8'h18, 8'hA9, 8'h69, 8'h69, 8'h38, 8'h69, 8'h29, 8'h09,
		8'h49, 8'h4A, 8'h69, 8'hA2, 8'h8A, 8'hA9, 8'hAA, 8'hA9,
		8'h8A, 8'hFF, 8'h4C, 8'hA0, 8'h4A, 8'h38, 8'h69, 8'h69,
		8'hEA, 8'h4C, 8'h49, 8'h4A, 8'h69, 8'h18, 8'h69
	};

	typedef struct packed {
		byteT opc;
		byteT opnd;							// Immediate value, unused for implied
		logic doStore;						// Row followed by STA abs
		addrT stAddr;
		byteT expData;						// Accumulator after the row
	} rowT;

	logic phi0;
	logic rstN;
	logic rdy;
	addrT addr;
	logic rnw;
	logic sync;
	byteT dOut;
	byteT dIn;
	int unsigned writeCount;

	rowT rows [0:numRows-1];
	byteT mA;								// Model registers
	byteT mX;
	byteT mY;
	logic mC;
	logic [31:0] rngState;
	addrT expAddrQ[$];						// Expected stores in order
	byteT expDataQ[$];
	addrT jumpQ[$];							// JMP targets in order
	addrT jumpTarget;
	logic jumpPending;
	logic nextRdy;
	logic wasWrite;
	logic done;
	logic buildDone;
	int nInst;
	int nFetch;								// Fetches marked by SYNC
	int expCount;

	core6502 #(.resetPc(startPc)) i_core6502(
		.phi0(phi0), .rstN(rstN), .addr(addr), .rnw(rnw), .sync(sync),
		.dOut(dOut), .dIn(dIn), .rdy(rdy) );

	tbMemory i_mem(
		.phi0(phi0), .addr(addr), .rnw(rnw), .wData(dOut), .rData(dIn),
		.writeCount(writeCount) );

	initial begin
		phi0 = 1'b0;
		forever #10 phi0 = ~phi0;			// 20 ns period
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic checkAddr(input addrT got, input addrT exp, input string name);
		if (got !== exp)
			abortRun($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkByte(input byteT got, input byteT exp, input string name);
		if (got !== exp)
			abortRun($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	// Rows with operands and the model's register state after each one
	task automatic buildTable();
		int r;
		int sum;
		for (r = 0; r < numRows; r++) begin
			rows[r].opc = script[r];
			rngState = xorshift32(rngState);
			rows[r].opnd = rngState[7:0];
			case (script[r])
				8'hA9: mA = rows[r].opnd;
				8'hA2: mX = rows[r].opnd;
				8'hA0: mY = rows[r].opnd;
				8'h69: begin
					sum = int'(mA) + int'(rows[r].opnd) + int'(mC);
					mC = (sum >= 256);		// Carry past bit 7
					mA = 8'(sum);
				end
				8'h29: mA = mA & rows[r].opnd;
				8'h09: mA = mA | rows[r].opnd;
				8'h49: mA = mA ^ rows[r].opnd;
				8'h4A: begin
					mC = mA[0];				// Bit 0 out to carry
					mA = mA >> 1;
				end
				8'hAA: mX = mA;
				8'h8A: mA = mX;
				8'h18: mC = 1'b0;
				8'h38: mC = 1'b1;
				default: ;					// NOP, JMP, unknown
			endcase
			rows[r].doStore = !(script[r] inside {8'h18, 8'h38, 8'hA2, 8'hA0, 8'hAA, 8'h4C});
			rows[r].stAddr = {8'h40 + 8'(r), rngState[15:8]};	// Row-specific page
			rows[r].expData = mA;
		end
	endtask

	task automatic emit(inout addrT pc, input byteT d);
		i_mem.mem[pc] = d;
		pc = pc + 16'd1;
	endtask

	task automatic loadImage();
		int i;
		int r;
		int k;
		addrT pc;
		addrT target;
		for (i = 0; i < 65536; i++)
			i_mem.mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'hC3;	// Whole-address fill
		pc = startPc;
		nInst = 1;
		for (r = 0; r < numRows; r++) begin
			emit(pc, rows[r].opc);
			if (rows[r].opc == 8'h4C) begin
				target = pc + 16'd6;		// Over operands and decoys
				emit(pc, target[7:0]);
				emit(pc, target[15:8]);
				for (k = 0; k < 2; k++) begin
					emit(pc, 8'hA9);		// LDA # decoy corrupts A if run
					emit(pc, ~rows[r].expData);
				end
				jumpQ.push_back(target);
			end else if (rows[r].opc inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'h29, 8'h09, 8'h49})
				emit(pc, rows[r].opnd);
			if (rows[r].doStore) begin
				emit(pc, 8'h8D);
				emit(pc, rows[r].stAddr[7:0]);
				emit(pc, rows[r].stAddr[15:8]);
				expAddrQ.push_back(rows[r].stAddr);
				expDataQ.push_back(rows[r].expData);
				nInst++;
			end
			nInst++;
		end
		// Park the core on a JMP to itself
		target = pc;
		emit(pc, 8'h4C);
		emit(pc, target[7:0]);
		emit(pc, target[15:8]);
		expCount = expAddrQ.size();
	endtask

	initial begin
		rstN = 1'b0;
		rdy = 1'b1;
		buildDone = 1'b0;
		done = 1'b0;
		wasWrite = 1'b0;
		jumpPending = 1'b0;
		jumpTarget = 16'h0000;
		nFetch = 0;
		mA = 8'h00;							// Core resets A, X, Y, P to zero
		mX = 8'h00;
		mY = 8'h00;
		mC = 1'b0;
		rngState = 32'hdd57884a;
		buildTable();
		loadImage();
		buildDone = 1'b1;
		repeat (2) @(posedge phi0);
		@(negedge phi0);
		rstN = 1'b1;
		while (!done) begin
			rngState = xorshift32(rngState);
			nextRdy = (rngState[1:0] != 2'b00);	// Low about a quarter of the time
			// Fetch completes on the coming edge
			if (sync && nextRdy) begin
				nFetch++;
				if (jumpPending)
					checkAddr(addr, jumpTarget, "addr at fetch after JMP");
				jumpPending = (dIn == 8'h4C) && (jumpQ.size() != 0);
				if (jumpPending)
					jumpTarget = jumpQ.pop_front();
			end
			if (!rnw) begin
				if (wasWrite)
					abortRun("A write cycle lasted more than one clock");
				checkAddr(addr, expAddrQ.pop_front(), "addr");
				checkByte(dOut, expDataQ.pop_front(), "dOut");
				done = (expAddrQ.size() == 0);
			end
			wasWrite = !rnw;
			rdy = nextRdy;
			if (!done)
				@(negedge phi0);
		end
		// Every row and every STA fetched once, decoys never
		if (nFetch != nInst - 1)
			abortRun($sformatf("** Error at %0t: sync fetches = %0d, expected %0d",
				$time, nFetch, nInst - 1));
		rdy = 1'b1;
		repeat (8) @(negedge phi0);			// Core idles on the parking JMP
		if (writeCount == expCount) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else
			abortRun("Memory write log count differs from the number of expected stores");
	end

	// Every instruction at most 4 cycles, stalls at most triple that
	initial begin
		wait (buildDone);
		repeat (nInst * 4 * 3 + 50) @(posedge phi0);
		abortRun("Watchdog expired: the core hung before all expected stores were seen");
	end

endmodule

`default_nettype wire

/* sim/tbMemory.sv */
// Testbench memory: 64 KiB byte array on the core bus, with a running count of write cycles
`timescale 1ns/1ps
`default_nettype none

module tbMemory import core6502Pkg::*; (
	input logic phi0,
	input addrT addr,
	input logic rnw,						// Low on core store cycles
	input byteT wData,						// Core dOut
	output byteT rData,						// Core dIn
	output int unsigned writeCount			// Write log seen by the bench
);

	byteT mem [0:65535];					// Fill and program image come from the bench

	assign rData = mem[addr];				// Asynchronous read, RDY handled by the bench

	initial writeCount = 0;

	// Store on the edge that ends the write cycle
	always @(posedge phi0) begin
		if (!rnw) begin
			mem[addr] = wData;
			writeCount = writeCount + 1;
		end
	end

endmodule

`default_nettype wire
